/* integrity_pkg.sv */
////////////////////////////////////////
// Bus integrity unit shared definitions
// Widths, channel indices, NMI causes and
// the bus and context structs
////////////////////////////////////////

package integrity_pkg;

  // Channel layout
  localparam int NUM_CHAN = 2;
  localparam int CH_INSTR = 0;
  localparam int CH_DATA  = 1;

  // Bus field widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int BE_W      = 4;
  localparam int PROT_W    = 3;
  localparam int MEMTYPE_W = 2;
  localparam int ATOP_W    = 6;

  // Checksum widths and the err/exokay bit of rchk
  localparam int ACHK_W       = 12;
  localparam int RCHK_W       = 5;
  localparam int RCHK_ERR_BIT = 4;

  // Outstanding request tracking
  localparam int TRACK_DEPTH = 2;
  localparam int TRACK_PTR_W = $clog2(TRACK_DEPTH);
  localparam int TRACK_CNT_W = $clog2(TRACK_DEPTH + 1);

  // Fields that are not carried by this unit
  localparam logic [ATOP_W-1:0] ATOP_TIE_OFF   = '0;
  localparam logic              EXOKAY_TIE_OFF = 1'b0;

  // Instruction fetches are full-word loads with no write data
  localparam logic [BE_W-1:0]   INSTR_BE    = '1;
  localparam logic              INSTR_WE    = 1'b0;
  localparam logic [DATA_W-1:0] INSTR_WDATA = '0;

  // NMI causes
  localparam int                 CAUSE_W           = 11;
  localparam logic [CAUSE_W-1:0] CAUSE_LOAD_FAULT  = 11'h402;
  localparam logic [CAUSE_W-1:0] CAUSE_STORE_FAULT = 11'h403;

  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    logic [PROT_W-1:0]    prot;
    logic [MEMTYPE_W-1:0] memtype;
    logic [BE_W-1:0]      be;
    logic                 we;
    logic                 dbg;
    logic [DATA_W-1:0]    wdata;
  } obi_req_t;

  typedef struct packed {
    logic     req;
    logic     gnt;
    logic     gntpar;
    obi_req_t pkt;
  } chan_req_t;

  typedef struct packed {
    logic              rvalid;
    logic              rvalidpar;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
  } chan_resp_t;

  typedef struct packed {
    logic had_integrity;
    logic was_store;
    logic gnt_par_err;
  } req_ctx_t;

  // Context given to a response that finds no tracked request
  localparam req_ctx_t CTX_EMPTY = '{had_integrity: 1'b0, was_store: 1'b0, gnt_par_err: 1'b0};

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              integrity_err;
    logic              rchk_fault;
    logic              par_fault;
    logic              was_store;
  } chk_out_t;

endpackage

/* achk_gen.sv */
////////////////////////////////////////
// Request checksum generator
// Byte parities of the request per channel
////////////////////////////////////////

`timescale 1ns/1ps

module achk_gen (
  input  integrity_pkg::chan_req_t [integrity_pkg::NUM_CHAN-1:0]                             req,
  output logic [integrity_pkg::NUM_CHAN-1:0][integrity_pkg::ACHK_W-1:0]                      achk,
  output logic [integrity_pkg::NUM_CHAN-1:0]                                                 reqpar
);

  always_comb begin
    integrity_pkg::obi_req_t pkt;

    for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
      pkt = req[ch].pkt;

      // Fetches never write, so the store fields are fixed
      if (ch == integrity_pkg::CH_INSTR) begin
        pkt.be    = integrity_pkg::INSTR_BE;
        pkt.we    = integrity_pkg::INSTR_WE;
        pkt.wdata = integrity_pkg::INSTR_WDATA;
      end

      achk[ch] = {
        ^pkt.wdata[31:24],
        ^pkt.wdata[23:16],
        ^pkt.wdata[15:8],
        ^pkt.wdata[7:0],
        ^integrity_pkg::ATOP_TIE_OFF,
        ~^pkt.dbg,
        ~^{pkt.be, pkt.we},
        ~^{pkt.prot, pkt.memtype},
        ^pkt.addr[31:24],
        ^pkt.addr[23:16],
        ^pkt.addr[15:8],
        ^pkt.addr[7:0]
      };

      reqpar[ch] = ~req[ch].req;
    end
  end

endmodule

/* req_tracker.sv */
////////////////////////////////////////
// Outstanding request tracker
// In-order context FIFO per channel
////////////////////////////////////////

`timescale 1ns/1ps

module req_tracker (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n,
  input  logic                                                  integrity_enabled,
  input  integrity_pkg::chan_req_t  [integrity_pkg::NUM_CHAN-1:0] req,
  input  integrity_pkg::chan_resp_t [integrity_pkg::NUM_CHAN-1:0] resp,
  output integrity_pkg::req_ctx_t   [integrity_pkg::NUM_CHAN-1:0] ctx
);

  localparam int PTR_W = integrity_pkg::TRACK_PTR_W;
  localparam int CNT_W = integrity_pkg::TRACK_CNT_W;

  for (genvar g = 0; g < integrity_pkg::NUM_CHAN; g++) begin : g_chan
    integrity_pkg::req_ctx_t mem [integrity_pkg::TRACK_DEPTH];
    integrity_pkg::req_ctx_t new_ctx;
    integrity_pkg::req_ctx_t head_ctx;
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    grant;
    logic                    gnt_mismatch;
    logic                    empty;
    logic                    full;
    logic                    push;
    logic                    pop;

    assign grant        = req[g].req & req[g].gnt;
    assign gnt_mismatch = (req[g].gntpar == req[g].gnt);
    assign empty        = (count == '0);
    assign full         = (count == CNT_W'(integrity_pkg::TRACK_DEPTH));
    assign pop          = resp[g].rvalid & ~empty;
    // A grant into a full FIFO is dropped unless an entry leaves in the same cycle
    assign push         = grant & (~full | pop);

    assign new_ctx.had_integrity = integrity_enabled;
    assign new_ctx.was_store     = (g == integrity_pkg::CH_INSTR) ? 1'b0 : req[g].pkt.we;
    assign new_ctx.gnt_par_err   = gnt_mismatch;

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr] <= new_ctx;
      end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PTR_W'(integrity_pkg::TRACK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == PTR_W'(integrity_pkg::TRACK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    assign head_ctx = empty ? integrity_pkg::CTX_EMPTY : mem[rd_ptr];

    assign ctx[g].had_integrity = head_ctx.had_integrity;
    assign ctx[g].was_store     = head_ctx.was_store;
    // Stored grant error only counts on its response, a live one is passed on at once
    assign ctx[g].gnt_par_err   = (resp[g].rvalid & head_ctx.gnt_par_err) | gnt_mismatch;
  end

endmodule

/* resp_checker.sv */
////////////////////////////////////////
// Response checker for one channel
// Checks rchk and rvalid parity, registers
// the annotated response
////////////////////////////////////////

`timescale 1ns/1ps

module resp_checker (
  input  logic                    clk_i,
  input  logic                    arst_n,
  input  logic                    integrity_enabled,
  input  integrity_pkg::chan_resp_t resp,
  input  integrity_pkg::req_ctx_t   ctx,
  output integrity_pkg::chk_out_t   out
);

  logic [integrity_pkg::RCHK_W-1:0] exp_rchk;
  logic                             rchk_mismatch;
  logic                             rchk_fault;
  logic                             par_fault;
  logic                             integrity_err;

  logic                               valid_q;
  logic                               integrity_err_q;
  logic                               rchk_fault_q;
  logic                               par_fault_q;
  logic [integrity_pkg::DATA_W-1:0]   rdata_q;
  logic                               err_q;
  logic                               was_store_q;

  assign exp_rchk = {
    ^{resp.err, integrity_pkg::EXOKAY_TIE_OFF},
    ^resp.rdata[31:24],
    ^resp.rdata[23:16],
    ^resp.rdata[15:8],
    ^resp.rdata[7:0]
  };

  // Stores return no data, only the err bit is covered
  assign rchk_mismatch = ctx.was_store ?
    (resp.rchk[integrity_pkg::RCHK_ERR_BIT] != exp_rchk[integrity_pkg::RCHK_ERR_BIT]) :
    (resp.rchk != exp_rchk);

  assign rchk_fault    = resp.rvalid & integrity_enabled & ctx.had_integrity & rchk_mismatch;
  // rvalid parity is watched every cycle, not only on responses
  assign par_fault     = (resp.rvalidpar == resp.rvalid) | ctx.gnt_par_err;
  assign integrity_err = resp.rvalid & (rchk_fault | par_fault);

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      valid_q         <= 1'b0;
      integrity_err_q <= 1'b0;
      rchk_fault_q    <= 1'b0;
      par_fault_q     <= 1'b0;
    end else begin
      valid_q         <= resp.rvalid;
      integrity_err_q <= integrity_err;
      rchk_fault_q    <= rchk_fault;
      par_fault_q     <= par_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp.rvalid) begin
      rdata_q     <= resp.rdata;
      err_q       <= resp.err;
      was_store_q <= ctx.was_store;
    end
  end

  always_comb begin
    out.valid         = valid_q;
    out.rdata         = rdata_q;
    out.err           = err_q;
    out.integrity_err = integrity_err_q;
    out.rchk_fault    = rchk_fault_q;
    out.par_fault     = par_fault_q;
    out.was_store     = was_store_q;
  end

endmodule

/* alert_collector.sv */
////////////////////////////////////////
// Alert and NMI collector
// Major alert from any channel fault and
// a held NMI for data integrity errors
////////////////////////////////////////

`timescale 1ns/1ps

module alert_collector (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n,
  input  integrity_pkg::chk_out_t [integrity_pkg::NUM_CHAN-1:0] chk,
  input  logic                                                 nmi_ack,
  output logic                                                 alert_major,
  output logic                                                 nmi_pending,
  output logic [integrity_pkg::CAUSE_W-1:0]                    nmi_cause
);

  logic nmi_set;

  // Fault flags arrive registered, so the alert lands one cycle after the fault
  always_comb begin
    alert_major = 1'b0;
    for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
      alert_major = alert_major | chk[ch].rchk_fault | chk[ch].par_fault;
    end
  end

  // Only the data channel raises an NMI
  assign nmi_set = chk[integrity_pkg::CH_DATA].valid &
                   chk[integrity_pkg::CH_DATA].integrity_err;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      nmi_pending <= 1'b0;
      nmi_cause   <= '0;
    end else begin
      if (nmi_set) begin
        nmi_pending <= 1'b1;
        // First error keeps its cause until acknowledged
        if (!nmi_pending || nmi_ack) begin
          nmi_cause <= chk[integrity_pkg::CH_DATA].was_store ?
                       integrity_pkg::CAUSE_STORE_FAULT :
                       integrity_pkg::CAUSE_LOAD_FAULT;
        end
      end else if (nmi_ack) begin
        nmi_pending <= 1'b0;
      end
    end
  end

endmodule

/* integrity_unit.sv */
////////////////////////////////////////
// Bus integrity unit top level
// Checksum generation, response checks,
// major alert and NMI for two OBI channels
////////////////////////////////////////

`timescale 1ns/1ps

module integrity_unit (
  input  logic                                                        clk_i,
  input  logic                                                        arst_n,
  input  logic                                                        integrity_enabled,
  input  integrity_pkg::chan_req_t  [integrity_pkg::NUM_CHAN-1:0]     req,
  input  integrity_pkg::chan_resp_t [integrity_pkg::NUM_CHAN-1:0]     resp,
  input  logic                                                        nmi_ack,
  output logic [integrity_pkg::NUM_CHAN-1:0][integrity_pkg::ACHK_W-1:0] achk,
  output logic [integrity_pkg::NUM_CHAN-1:0]                          reqpar,
  output integrity_pkg::chk_out_t   [integrity_pkg::NUM_CHAN-1:0]     chk,
  output logic                                                        alert_major,
  output logic                                                        nmi_pending,
  output logic [integrity_pkg::CAUSE_W-1:0]                           nmi_cause
);

  // Head context of each channel, valid while rvalid is high
  integrity_pkg::req_ctx_t [integrity_pkg::NUM_CHAN-1:0] ctx;

  achk_gen achk_gen_i (
    .req    (req),
    .achk   (achk),
    .reqpar (reqpar)
  );

  req_tracker req_tracker_i (
    .clk_i             (clk_i),
    .arst_n            (arst_n),
    .integrity_enabled (integrity_enabled),
    .req               (req),
    .resp              (resp),
    .ctx               (ctx)
  );

  for (genvar g = 0; g < integrity_pkg::NUM_CHAN; g++) begin : g_chk
    resp_checker resp_checker_i (
      .clk_i             (clk_i),
      .arst_n            (arst_n),
      .integrity_enabled (integrity_enabled),
      .resp              (resp[g]),
      .ctx               (ctx[g]),
      .out               (chk[g])
    );
  end

  alert_collector alert_collector_i (
    .clk_i       (clk_i),
    .arst_n      (arst_n),
    .chk         (chk),
    .nmi_ack     (nmi_ack),
    .alert_major (alert_major),
    .nmi_pending (nmi_pending),
    .nmi_cause   (nmi_cause)
  );

endmodule

/* tb_clkgen.sv */
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_i,
  output logic arst_n
);

  // 20 ns period
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Reset held for 10 cycles, released on a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n <= 1'b1;
  end

endmodule

/* tb_checker.sv */
////////////////////////////////////////
// Testbench checker
// Reference model of the integrity unit,
// compares every output each cycle
////////////////////////////////////////

`timescale 1ns/1ps

module tb_checker (
  input  logic                                                          clk_i,
  input  logic                                                          arst_n,
  input  logic                                                          integrity_enabled,
  input  logic                                                          nmi_ack,
  input  integrity_pkg::chan_req_t  [integrity_pkg::NUM_CHAN-1:0]       req,
  input  integrity_pkg::chan_resp_t [integrity_pkg::NUM_CHAN-1:0]       resp,
  input  logic [integrity_pkg::NUM_CHAN-1:0][integrity_pkg::ACHK_W-1:0] achk,
  input  logic [integrity_pkg::NUM_CHAN-1:0]                            reqpar,
  input  integrity_pkg::chk_out_t   [integrity_pkg::NUM_CHAN-1:0]       chk,
  input  logic                                                          alert_major,
  input  logic                                                          nmi_pending,
  input  logic [integrity_pkg::CAUSE_W-1:0]                             nmi_cause,
  output int                                                            check_count,
  output int                                                            error_count
);

  // Outstanding request context per channel, oldest first
  integrity_pkg::req_ctx_t           ctx_q [integrity_pkg::NUM_CHAN][$];
  integrity_pkg::chk_out_t           exp_chk [integrity_pkg::NUM_CHAN];
  logic                              exp_nmi;
  logic [integrity_pkg::CAUSE_W-1:0] exp_cause;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  function automatic logic [integrity_pkg::ACHK_W-1:0] model_achk(
    input int ch,
    input integrity_pkg::obi_req_t p
  );
    if (ch == integrity_pkg::CH_INSTR) begin
      p.be    = '1;
      p.we    = 1'b0;
      p.wdata = '0;
    end
    return {^p.wdata[31:24], ^p.wdata[23:16], ^p.wdata[15:8], ^p.wdata[7:0], 1'b0, !p.dbg,
            ~^{p.be, p.we}, ~^{p.prot, p.memtype},
            ^p.addr[31:24], ^p.addr[23:16], ^p.addr[15:8], ^p.addr[7:0]};
  endfunction

  // exokay is zero, so the top bit is the parity of err alone
  function automatic logic [integrity_pkg::RCHK_W-1:0] model_rchk(
    input integrity_pkg::chan_resp_t r
  );
    return {r.err, ^r.rdata[31:24], ^r.rdata[23:16], ^r.rdata[15:8], ^r.rdata[7:0]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  always @(negedge clk_i) begin : model_step
    integrity_pkg::req_ctx_t          head;
    integrity_pkg::req_ctx_t          entry;
    integrity_pkg::chk_out_t          nxt;
    logic [integrity_pkg::RCHK_W-1:0] exp_rchk;
    logic                             mismatch;
    logic                             gnt_bad;
    logic                             alert_exp;
    logic                             nmi_set;
    if (!arst_n) begin
      for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
        ctx_q[ch].delete();
        exp_chk[ch] = '0;
      end
      exp_nmi   = 1'b0;
      exp_cause = '0;
    end else begin
      alert_exp = 1'b0;
      for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
        compare_value($sformatf("achk[%0d]", ch), achk[ch], model_achk(ch, req[ch].pkt));
        compare_value($sformatf("reqpar[%0d]", ch), reqpar[ch], !req[ch].req);
        compare_value($sformatf("chk[%0d].valid", ch), chk[ch].valid, exp_chk[ch].valid);
        compare_value($sformatf("chk[%0d].integrity_err", ch), chk[ch].integrity_err,
                      exp_chk[ch].integrity_err);
        compare_value($sformatf("chk[%0d].rchk_fault", ch), chk[ch].rchk_fault,
                      exp_chk[ch].rchk_fault);
        compare_value($sformatf("chk[%0d].par_fault", ch), chk[ch].par_fault,
                      exp_chk[ch].par_fault);
        if (exp_chk[ch].valid) begin
          compare_value($sformatf("chk[%0d].rdata", ch), chk[ch].rdata, exp_chk[ch].rdata);
          compare_value($sformatf("chk[%0d].err", ch), chk[ch].err, exp_chk[ch].err);
          compare_value($sformatf("chk[%0d].was_store", ch), chk[ch].was_store,
                        exp_chk[ch].was_store);
        end
        alert_exp = alert_exp | exp_chk[ch].rchk_fault | exp_chk[ch].par_fault;
      end
      compare_value("alert_major", alert_major, alert_exp);
      compare_value("nmi_pending", nmi_pending, exp_nmi);
      compare_value("nmi_cause", nmi_cause, exp_cause);

      // NMI follows the registered data-channel result
      nmi_set = exp_chk[integrity_pkg::CH_DATA].valid &
                exp_chk[integrity_pkg::CH_DATA].integrity_err;
      if (nmi_set && (!exp_nmi || nmi_ack)) begin
        exp_cause = exp_chk[integrity_pkg::CH_DATA].was_store ?
                    integrity_pkg::CAUSE_STORE_FAULT : integrity_pkg::CAUSE_LOAD_FAULT;
      end
      if (nmi_set) begin
        exp_nmi = 1'b1;
      end else if (nmi_ack) begin
        exp_nmi = 1'b0;
      end

      for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
        head    = '0;
        gnt_bad = (req[ch].gntpar == req[ch].gnt);
        if (resp[ch].rvalid && ctx_q[ch].size() > 0) begin
          head = ctx_q[ch].pop_front();
        end
        exp_rchk = model_rchk(resp[ch]);
        // Stores only cover the err bit
        mismatch = head.was_store ?
          (resp[ch].rchk[integrity_pkg::RCHK_ERR_BIT] != exp_rchk[integrity_pkg::RCHK_ERR_BIT]) :
          (resp[ch].rchk != exp_rchk);
        nxt               = exp_chk[ch];
        nxt.valid         = resp[ch].rvalid;
        nxt.rchk_fault    = resp[ch].rvalid & integrity_enabled & head.had_integrity & mismatch;
        nxt.par_fault     = (resp[ch].rvalidpar == resp[ch].rvalid) | gnt_bad |
                            (resp[ch].rvalid & head.gnt_par_err);
        nxt.integrity_err = resp[ch].rvalid & (nxt.rchk_fault | nxt.par_fault);
        if (resp[ch].rvalid) begin
          nxt.rdata     = resp[ch].rdata;
          nxt.err       = resp[ch].err;
          nxt.was_store = head.was_store;
        end
        exp_chk[ch] = nxt;
        if (req[ch].req && req[ch].gnt && ctx_q[ch].size() < integrity_pkg::TRACK_DEPTH) begin
          entry.had_integrity = integrity_enabled;
          entry.was_store     = (ch == integrity_pkg::CH_DATA) && req[ch].pkt.we;
          entry.gnt_par_err   = gnt_bad;
          ctx_q[ch].push_back(entry);
        end
      end
    end
  end

endmodule

/* tb_integrity_unit.sv */
////////////////////////////////////////
// Integrity unit testbench
// Random OBI traffic with injected faults
////////////////////////////////////////

`timescale 1ns/1ps

module tb_integrity_unit;

  logic                                                          clk_i;
  logic                                                          arst_n;
  logic                                                          integrity_enabled;
  logic                                                          nmi_ack;
  integrity_pkg::chan_req_t  [integrity_pkg::NUM_CHAN-1:0]       req;
  integrity_pkg::chan_resp_t [integrity_pkg::NUM_CHAN-1:0]       resp;
  logic [integrity_pkg::NUM_CHAN-1:0][integrity_pkg::ACHK_W-1:0] achk;
  logic [integrity_pkg::NUM_CHAN-1:0]                            reqpar;
  integrity_pkg::chk_out_t   [integrity_pkg::NUM_CHAN-1:0]       chk;
  logic                                                          alert_major;
  logic                                                          nmi_pending;
  logic [integrity_pkg::CAUSE_W-1:0]                             nmi_cause;
  int                                                            check_count;
  int                                                            error_count;

  int unsigned seed = 32'd52842;
  int          outstanding [integrity_pkg::NUM_CHAN];
  // Fault chances out of 64
  int          p_rchk_lo, p_rchk_hi, p_rvpar, p_gntpar, p_toggle, p_ack;

  tb_clkgen      clkgen_i (.*);
  integrity_unit dut_i (.*);
  tb_checker     checker_i (.*);

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Value in 0 .. n-1 from the upper LCG bits
  function automatic int unsigned rand_below(input int unsigned n);
    seed = lcg_next(seed);
    return (seed >> 8) % n;
  endfunction

  function automatic logic chance(input int unsigned k);
    return rand_below(64) < k;
  endfunction

  function automatic logic [31:0] rand_word();
    return (rand_below(32'h10000) << 16) | rand_below(32'h10000);
  endfunction

  task automatic set_faults(input int lo, input int hi, input int rvpar, input int gntpar,
                            input int toggle, input int ack);
    p_rchk_lo = lo;
    p_rchk_hi = hi;
    p_rvpar   = rvpar;
    p_gntpar  = gntpar;
    p_toggle  = toggle;
    p_ack     = ack;
  endtask

  task automatic drive_cycle(input logic grant_ok);
    integrity_pkg::chan_req_t  r;
    integrity_pkg::chan_resp_t s;
    logic [95:0]               bits;
    @(posedge clk_i);
    for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
      s = '0;
      // In-order response to an earlier grant
      if (outstanding[ch] > 0 && chance(24)) begin
        outstanding[ch]--;
        s.rvalid = 1'b1;
        s.rdata  = rand_word();
        s.err    = chance(6);
        s.rchk   = {s.err, ^s.rdata[31:24], ^s.rdata[23:16], ^s.rdata[15:8], ^s.rdata[7:0]};
        if (chance(p_rchk_lo)) begin
          s.rchk[3:0] = s.rchk[3:0] ^ 4'(rand_below(15) + 1);
        end
        if (chance(p_rchk_hi)) begin
          s.rchk[4] = ~s.rchk[4];
        end
      end
      s.rvalidpar = chance(p_rvpar) ? s.rvalid : ~s.rvalid;
      bits     = {rand_word(), rand_word(), rand_word()};
      r        = '0;
      r.pkt    = bits[$bits(integrity_pkg::obi_req_t)-1:0];
      r.req    = chance(40);
      r.gnt    = grant_ok & r.req & (outstanding[ch] < integrity_pkg::TRACK_DEPTH) & chance(40);
      outstanding[ch] += r.gnt;
      r.gntpar = chance(p_gntpar) ? r.gnt : ~r.gnt;
      req[ch]  <= r;
      resp[ch] <= s;
    end
    if (p_toggle == 0) begin
      integrity_enabled <= 1'b1;
    end else if (chance(p_toggle)) begin
      integrity_enabled <= ~integrity_enabled;
    end
    nmi_ack <= chance(p_ack);
  endtask

  task automatic run_test(input int num, input string name, input int cycles,
                          output logic drained);
    int guard;
    int base_err;
    int base_chk;
    base_err = error_count;
    base_chk = check_count;
    guard    = 0;
    for (int i = 0; i < cycles; i++) begin
      drive_cycle(1'b1);
    end
    // Let every outstanding request get its response
    while ((outstanding[0] + outstanding[1]) > 0 && guard < 200) begin
      drive_cycle(1'b0);
      guard++;
    end
    drained = ((outstanding[0] + outstanding[1]) == 0);
    if (!drained) begin
      $display("test %0d %s: outstanding responses did not drain", num, name);
    end else begin
      repeat (4) drive_cycle(1'b0);
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               check_count - base_chk, error_count - base_err);
    end
  endtask

  initial begin
    int   guard;
    logic ok;
    integrity_enabled = 1'b1;
    nmi_ack           = 1'b0;
    req               = '0;
    resp              = '0;
    for (int ch = 0; ch < integrity_pkg::NUM_CHAN; ch++) begin
      req[ch].gntpar     = 1'b1;
      resp[ch].rvalidpar = 1'b1;
      outstanding[ch]    = 0;
    end
    guard = 0;
    while (arst_n !== 1'b1 && guard < 40) begin
      @(posedge clk_i);
      guard++;
    end
    ok = (arst_n === 1'b1);
    if (!ok) begin
      $display("reset was never released");
    end
    if (ok) begin
      set_faults(0, 0, 0, 0, 0, 2);
      run_test(1, "clean traffic", 300, ok);
    end
    if (ok) begin
      set_faults(10, 0, 0, 0, 3, 2);
      run_test(2, "load rchk with enable toggling", 400, ok);
    end
    if (ok) begin
      set_faults(12, 6, 0, 0, 0, 2);
      run_test(3, "store rchk bits", 400, ok);
    end
    if (ok) begin
      set_faults(0, 0, 3, 3, 0, 2);
      run_test(4, "rvalid and grant parity", 400, ok);
    end
    if (ok) begin
      set_faults(0, 6, 1, 1, 2, 1);
      run_test(5, "nmi cause and ack", 400, ok);
    end
    $display("total: %0d checks, %0d errors", check_count, error_count);
    if (ok && error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src.f */
integrity_pkg.sv
achk_gen.sv
req_tracker.sv
resp_checker.sv
alert_collector.sv
integrity_unit.sv
tb_clkgen.sv
tb_checker.sv
tb_integrity_unit.sv

/* Bender.yml */
package:
  name: integrity_unit

sources:
  - integrity_pkg.sv
  - achk_gen.sv
  - req_tracker.sv
  - resp_checker.sv
  - alert_collector.sv
  - integrity_unit.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_checker.sv
      - tb_integrity_unit.sv
